// ==== Makefile ====
# Verilator build and run of the FPU testbench
VERILATOR ?= verilator
TOP       ?= fpu_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUNFLAGS  ?= +verilator+error+limit+1000
FAIL_MSG  := Done: errors found
PASS_MSG  := Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) $(RUNFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "FAIL: run did not complete"; exit 1; }
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/fpu_assert.sv ====
// FPU checker bound to the top level: delayed operand pipe, reference model, concurrent checks
module fpu_assert
	import fp_format_pkg::*, fpu_ctrl_pkg::*;
(
	input logic       fpu_if,
	input logic       arst_n,
	input fp_word_t   opa,
	input fp_word_t   opb,
	input logic [1:0] fpu_op,
	input fp_word_t   result,
	input fpu_flags_t flags
);
	timeunit 1ns;
	timeprecision 100ps;

	fp_word_t    opa_d [FPU_LATENCY+1];   // Entry 0 mirrors the capture register
	fp_word_t    opb_d [FPU_LATENCY+1];
	logic [1:0]  op_d  [FPU_LATENCY+1];
	int unsigned cnt;                      // Captures since reset, saturating
	int unsigned fail_cnt = 0;             // Watched by the testbench
	fp_word_t    exp_word;
	logic        exp_special;
	fpu_flags_t  exp_flags;

	//////////////////////////////////////////////////////////////////////
	// Reference model
	function automatic logic is_snan(input fp_word_t w);
		return (&w[30:23]) && (w[22:0] != '0) && !w[22];
	endfunction

	// Single to double, denormals read as signed zero
	function automatic real to_real(input fp_word_t w);
		logic [10:0] e;
		e = 11'(w[30:23]) + 11'd896;           // Rebias 127 -> 1023
		if (w[30:23] == '0)
			return $bitstoreal({w[31], 63'b0});
		return $bitstoreal({w[31], e, w[22:0], 29'b0});
	endfunction

	// Double to single, one round to nearest even, then overflow and flush
	function automatic fp_word_t to_single(input real r);
		logic [63:0] d;
		logic [24:0] m;
		int          e;
		d = $realtobits(r);
		if (d[62:0] == '0)
			return {d[63], 31'b0};
		e = int'(d[62:52]) - 896;
		m = {2'b01, d[51:29]};
		if (d[28] && ((|d[27:0]) || m[0]))
			m = m + 25'd1;
		if (m[24]) begin                       // Rounded up to 2.0
			e = e + 1;
			m = m >> 1;
		end
		if (e >= EXP_MAX)
			return {d[63], FP_INF_MAG[30:0]};
		if (e < 1)
			return {d[63], 31'b0};             // Below min normal
		return {d[63], e[7:0], m[22:0]};
	endfunction

	function automatic void predict(input fp_word_t a, input fp_word_t b, input logic [1:0] op,
			output fp_word_t word, output logic special);
		logic nan_a, nan_b, inf_a, inf_b, zero_a, zero_b, is_mul, sign_b;
		real  r;
		nan_a   = (&a[30:23]) && (a[22:0] != '0);
		nan_b   = (&b[30:23]) && (b[22:0] != '0);
		inf_a   = (a[30:0] == FP_INF_MAG[30:0]);
		inf_b   = (b[30:0] == FP_INF_MAG[30:0]);
		zero_a  = (a[30:23] == '0);
		zero_b  = (b[30:23] == '0);
		is_mul  = op[1];                       // Codes 2 and 3
		sign_b  = b[31] ^ (op == 2'd1);        // Subtract flips b
		special = nan_a || nan_b || inf_a || inf_b;
		if (nan_a || nan_b)
			word = FP_QNAN;
		else if (is_mul && ((inf_a && zero_b) || (zero_a && inf_b)))
			word = FP_QNAN;                    // inf * 0
		else if (!is_mul && inf_a && inf_b && (a[31] != sign_b))
			word = FP_QNAN;                    // inf - inf
		else if (inf_a || inf_b)
			word = {is_mul ? a[31] ^ b[31] : (inf_a ? a[31] : sign_b), FP_INF_MAG[30:0]};
		else begin
			if (is_mul)
				r = to_real(a) * to_real(b);   // Exact in double
			else if (op == 2'd1)
				r = to_real(a) - to_real(b);
			else
				r = to_real(a) + to_real(b);
			word = to_single(r);
		end
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Operand pipe and expected outputs
	always_ff @(posedge fpu_if) begin
		opa_d[0] <= opa;
		opb_d[0] <= opb;
		op_d[0]  <= fpu_op;
		for (int i = 1; i <= FPU_LATENCY; i++) begin
			opa_d[i] <= opa_d[i-1];
			opb_d[i] <= opb_d[i-1];
			op_d[i]  <= op_d[i-1];
		end
	end

	always_ff @(posedge fpu_if or negedge arst_n) begin
		if (!arst_n)
			cnt <= 0;
		else if (cnt <= FPU_LATENCY)
			cnt <= cnt + 1;
	end

	always_comb begin
		predict(opa_d[FPU_LATENCY], opb_d[FPU_LATENCY], op_d[FPU_LATENCY], exp_word, exp_special);
		exp_flags.zero     = (exp_word[30:0] == '0);
		exp_flags.inf      = (exp_word[30:0] == FP_INF_MAG[30:0]);
		exp_flags.qnan     = (&exp_word[30:23]) && (exp_word[22:0] != '0);
		exp_flags.snan     = is_snan(opa_d[FPU_LATENCY]) || is_snan(opb_d[FPU_LATENCY]);
		exp_flags.overflow = exp_flags.inf && !exp_special;   // Only computed infinity
	end

	//////////////////////////////////////////////////////////////////////
	// Checks, sampled mid-cycle
	a_result: assert property (@(negedge fpu_if) (cnt > FPU_LATENCY) |-> (result == exp_word))
		else begin
			$error("mismatch result: expected %h, actual %h", exp_word, result);
			fail_cnt++;
		end

	a_flags: assert property (@(negedge fpu_if) (cnt > FPU_LATENCY) |-> (flags == exp_flags))
		else begin
			$error("mismatch flags: expected %h, actual %h", exp_flags, flags);
			fail_cnt++;
		end

	// Reset and pipeline fill
	a_reset_result: assert property (@(negedge fpu_if) (cnt <= FPU_LATENCY) |-> (result == '0))
		else begin
			$error("mismatch result after reset: expected 00000000, actual %h", result);
			fail_cnt++;
		end

	a_reset_flags: assert property (@(negedge fpu_if) (cnt <= FPU_LATENCY) |-> (flags == '0))
		else begin
			$error("mismatch flags after reset: expected 00, actual %h", flags);
			fail_cnt++;
		end

endmodule

bind fpu_top fpu_assert fpu_chk (
	.fpu_if (fpu_if),
	.arst_n (arst_n),
	.opa    (opa),
	.opb    (opb),
	.fpu_op (fpu_op),
	.result (result),
	.flags  (flags)
);

// ==== bench/fpu_tb.sv ====
// FPU testbench: clock and reset, directed and random operations, timeout, final verdict
module fpu_tb
	import fp_format_pkg::*, fpu_ctrl_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int RST_CYCLES = 3;
	localparam int N_DIRECTED = 18;
	localparam int N_RANDOM   = 400;
	// Reset, one idle op, directed, random, drain, then 40 spare
	localparam int MAX_CYCLES = RST_CYCLES + 1 + N_DIRECTED + N_RANDOM + FPU_LATENCY + 2 + 40;

	logic       fpu_if;
	logic       arst_n;
	fp_word_t   opa;
	fp_word_t   opb;
	fpu_op_e    fpu_op;
	fp_word_t   result;
	fpu_flags_t flags;
	int         seed;
	int         cycles = 0;

	fpu_top fpu_top_inst (
		.fpu_if (fpu_if),
		.arst_n (arst_n),
		.opa    (opa),
		.opb    (opb),
		.fpu_op (fpu_op),
		.result (result),
		.flags  (flags)
	);

	always #2 fpu_if = !fpu_if;                  // 4 ns period

	//////////////////////////////////////////////////////////////////////
	// Stimulus helpers, all driving on the falling edge
	task automatic issue(input fp_word_t a, input fp_word_t b, input fpu_op_e op);
		@(negedge fpu_if);
		opa    = a;
		opb    = b;
		fpu_op = op;
	endtask

	function automatic fp_word_t make_operand(input int e);
		logic [31:0] r;
		r = $random(seed);
		return {r[31], 8'(e), r[22:0]};          // Random sign and fraction
	endfunction

	// Exponents 100..154 and within 20, results stay normal
	task automatic issue_random();
		int ea, eb, op_sel;
		ea = 100 + int'({$random(seed)} % 55);
		eb = ea - 20 + int'({$random(seed)} % 41);
		if (eb < 100)
			eb = 100;
		if (eb > 154)
			eb = 154;
		op_sel = int'({$random(seed)} % 3);
		issue(make_operand(ea), make_operand(eb), fpu_op_e'(op_sel));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	initial begin
		fpu_if = 1'b0;
		arst_n = 1'b0;
		opa    = '0;
		opb    = '0;
		fpu_op = OP_ADD;
		seed   = 32'h19c7;
		repeat (RST_CYCLES) @(negedge fpu_if);
		arst_n = 1'b1;

		// Exact small-integer arithmetic and signed zeros
		issue(32'h4040_0000, 32'h4080_0000, OP_ADD);    // 3 + 4
		issue(32'h4040_0000, 32'h4040_0000, OP_SUB);    // 3 - 3 is +0
		issue(32'h8000_0000, 32'h8000_0000, OP_ADD);    // -0 + -0
		issue(32'h4020_0000, 32'hc0c0_0000, OP_MUL);    // 2.5 * -6
		issue(32'h4120_0000, 32'h4020_0000, OP_SUB);    // 10 - 2.5
		issue(32'h3fc0_0000, 32'hbfc0_0000, OP_ADD);    // 1.5 + -1.5
		issue(32'h4040_0000, 32'h4080_0000, fpu_op_e'(2'd3));  // Code 3 multiplies
		// Specials
		issue(32'h7f80_0000, 32'h7f80_0000, OP_SUB);    // inf - inf
		issue(32'h0000_0000, 32'h7f80_0000, OP_MUL);    // 0 * inf
		issue(32'h7f80_0000, 32'h3f80_0000, OP_ADD);    // inf + 1
		issue(32'h7f80_0001, 32'h3f80_0000, OP_ADD);    // Signaling NaN
		issue(32'h7fc0_0000, 32'h4000_0000, OP_MUL);    // Quiet NaN
		// Overflow, flush and denormal inputs
		issue(32'h7e80_0000, 32'h7e80_0000, OP_MUL);
		issue(32'hfe80_0000, 32'h7e80_0000, OP_MUL);
		issue(32'h0080_0000, 32'h0080_0000, OP_MUL);
		issue(32'h8080_0000, 32'h0080_0000, OP_MUL);
		issue(32'h0000_0001, 32'h3f80_0000, OP_ADD);    // Denormal plus one
		issue(32'h8040_0000, 32'h4000_0000, OP_MUL);    // Negative denormal times two

		// Back to back random traffic
		repeat (N_RANDOM) issue_random();

		repeat (FPU_LATENCY + 2) @(negedge fpu_if);
		if (fpu_top_inst.fpu_chk.fail_cnt == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			$display("Done: errors found");
			$fatal(1, "checks failed");
		end
	end

	//////////////////////////////////////////////////////////////////////
	// First failure and timeout watch
	always @(posedge fpu_if) begin
		cycles++;
		if (fpu_top_inst.fpu_chk.fail_cnt != 0) begin
			$display("Done: errors found");
			$fatal(1, "stopped at the first failed check");
		end else if (cycles >= MAX_CYCLES) begin
			$display("Done: errors found");
			$fatal(1, "timeout, stimulus did not finish within %0d cycles", MAX_CYCLES);
		end
	end

endmodule

// ==== design/fp_classify.sv ====
// Input capture stage with IEEE-754 operand classification and signaling NaN detect
module fp_classify
	import fp_format_pkg::*, fpu_ctrl_pkg::*;
(
	input  logic     fpu_if,
	input  logic     arst_n,
	input  fp_word_t opa,
	input  fp_word_t opb,
	input  fpu_op_e  fpu_op,
	fpu_opnd_if.cls  opnd
);

	// Decode exponent and fraction into a class
	function automatic fp_class_e classify(input fp_word_t w);
		fp_exp_t  e;
		fp_frac_t f;
		e = w[FP_W-2 -: EXP_W];
		f = w[FRAC_W-1:0];
		if (e == '0)
			return CLS_ZERO;                 // Denormals read as zero
		else if (e != fp_exp_t'(EXP_MAX))
			return CLS_NORMAL;
		else if (f == '0)
			return CLS_INF;
		else if (f[FRAC_W-1])
			return CLS_QNAN;                 // MSB of fraction set means quiet
		else
			return CLS_SNAN;
	endfunction

	always_ff @(posedge fpu_if or negedge arst_n) begin
		if (!arst_n) begin
			opnd.opa   <= '0;
			opnd.opb   <= '0;
			opnd.op    <= OP_ADD;
			opnd.cls_a <= CLS_ZERO;
			opnd.cls_b <= CLS_ZERO;
			opnd.snan  <= 1'b0;
		end else begin
			opnd.opa   <= opa;
			opnd.opb   <= opb;
			opnd.op    <= fpu_op;
			opnd.cls_a <= classify(opa);
			opnd.cls_b <= classify(opb);
			opnd.snan  <= (classify(opa) == CLS_SNAN) || (classify(opb) == CLS_SNAN);
		end
	end

endmodule

// ==== design/fp_format_pkg.sv ====
// binary32 field layout, datapath widths, special encodings and operand classes
package fp_format_pkg;

	//////////////////////////////////////////////////////////////////////
	// Field widths and exponent constants
	localparam int FP_W     = 32;
	localparam int EXP_W    = 8;
	localparam int FRAC_W   = 23;
	localparam int MANT_W   = FRAC_W + 1;      // Hidden bit included
	localparam int EXP_BIAS = 127;
	localparam int EXP_MAX  = 255;             // All-ones exponent

	// Internal datapath widths
	localparam int ALIGN_W  = MANT_W + 3;      // Mantissa plus guard, round, sticky
	localparam int WIDE_W   = 2 * MANT_W;      // Full product width
	localparam int PAD_W    = WIDE_W - ALIGN_W - 1;  // Zero fill below aligned sums
	localparam int LZ_W     = $clog2(WIDE_W + 1);

	typedef logic [FP_W-1:0]   fp_word_t;
	typedef logic [EXP_W-1:0]  fp_exp_t;
	typedef logic [FRAC_W-1:0] fp_frac_t;
	typedef logic [WIDE_W-1:0] fp_wide_t;

	// Two spare bits, product exponents run from about -171 to 382
	typedef logic signed [EXP_W+1:0] fp_exp_ext_t;

	//////////////////////////////////////////////////////////////////////
	// Special encodings
	localparam fp_word_t FP_INF_MAG = 32'h7f80_0000;  // Infinity, sign bit clear
	localparam fp_word_t FP_QNAN    = 32'h7fc0_0001;  // The one NaN we ever produce

	// Operand classes, denormals land in CLS_ZERO
	typedef enum logic [2:0] {
		CLS_NORMAL,
		CLS_ZERO,
		CLS_INF,
		CLS_QNAN,
		CLS_SNAN
	} fp_class_e;

endpackage

// ==== design/fpu_arith.sv ====
// Arithmetic stage: aligned fraction add/subtract and 24x24 mantissa multiply
module fpu_arith
	import fp_format_pkg::*, fpu_ctrl_pkg::*;
(
	input  logic     fpu_if,
	input  logic     arst_n,
	fpu_align_if.dst algn,
	fpu_align_if.src raw
);

	logic     is_mul;
	fp_wide_t raw_d;       // Carry or product MSB lands in the top bit

	always_comb begin
		is_mul = (algn.op != OP_ADD) && (algn.op != OP_SUB);
		if (is_mul)
			raw_d = algn.frac_a[MANT_W-1:0] * algn.frac_b[MANT_W-1:0];
		else if (algn.eff_sub)
			raw_d = algn.frac_a - algn.frac_b;   // Ordered, never negative
		else
			raw_d = algn.frac_a + algn.frac_b;
	end

	always_ff @(posedge fpu_if or negedge arst_n) begin
		if (!arst_n) begin
			raw.op           <= OP_ADD;
			raw.frac_a       <= '0;
			raw.frac_b       <= '0;
			raw.eff_sub      <= 1'b0;
			raw.sign         <= 1'b0;
			raw.exp          <= '0;
			raw.special      <= 1'b0;
			raw.special_word <= '0;
			raw.snan         <= 1'b0;
		end else begin
			raw.op           <= algn.op;
			raw.frac_a       <= raw_d;
			raw.frac_b       <= algn.frac_b;
			raw.eff_sub      <= algn.eff_sub;
			raw.sign         <= algn.sign;          // Sign, exponent and specials ride along
			raw.exp          <= algn.exp;
			raw.special      <= algn.special;
			raw.special_word <= algn.special_word;
			raw.snan         <= algn.snan;
		end
	end

endmodule

// ==== design/fpu_ctrl_pkg.sv ====
// FPU opcode encoding, status flag bundle and pipeline depth
package fpu_ctrl_pkg;

	// Opcode, code 3 decodes as multiply
	typedef enum logic [1:0] {
		OP_ADD = 2'd0,
		OP_SUB = 2'd1,
		OP_MUL = 2'd2
	} fpu_op_e;

	// Status flags, one bit each
	typedef struct packed {
		logic zero;
		logic inf;
		logic qnan;
		logic snan;
		logic overflow;
	} fpu_flags_t;

	// Capture edge to output edge
	localparam int FPU_LATENCY = 3;

endpackage

// ==== design/fpu_post_norm.sv ====
// Post-normalize stage: leading-one shift, round to nearest even, overflow, flush, flags
module fpu_post_norm
	import fp_format_pkg::*, fpu_ctrl_pkg::*;
(
	input  logic       fpu_if,
	input  logic       arst_n,
	fpu_align_if.dst   raw,
	output fp_word_t   result,
	output fpu_flags_t flags
);

	// Count of zeros above the leading one, WIDE_W when empty
	function automatic logic [LZ_W-1:0] lead_zeros(input fp_wide_t v);
		logic [LZ_W-1:0] n;
		logic            found;
		n     = '0;
		found = 1'b0;
		for (int i = WIDE_W - 1; i >= 0; i--) begin
			if (!found && !v[i])
				n = n + 1'b1;
			else
				found = 1'b1;
		end
		return n;
	endfunction

	logic [LZ_W-1:0] lz;
	fp_wide_t        norm;         // Leading one at the top bit
	logic            guard, sticky, round_up;
	logic [MANT_W:0] mant_r;       // Extra bit catches rounding carry
	fp_exp_ext_t     exp_n, exp_f;
	logic            is_zero, ovf, flush;
	fp_word_t        word;
	logic [1:0]      fill;         // Edges since reset, stops at the pipeline depth

	//////////////////////////////////////////////////////////////////////
	// Normalize and round
	always_comb begin
		is_zero  = (raw.frac_a == '0);
		lz       = lead_zeros(raw.frac_a);
		norm     = raw.frac_a << lz;
		guard    = norm[WIDE_W-MANT_W-1];
		sticky   = |norm[WIDE_W-MANT_W-2:0];
		round_up = guard && (sticky || norm[WIDE_W-MANT_W]);   // Ties go to even LSB
		mant_r   = {1'b0, norm[WIDE_W-1 -: MANT_W]} + (MANT_W+1)'(round_up);

		// Top bit of raw weighs 2^1, so one extra step up
		exp_n = raw.exp + fp_exp_ext_t'(1) - fp_exp_ext_t'(lz);
		exp_f = exp_n + fp_exp_ext_t'(mant_r[MANT_W]);          // Rounded up to 2.0

		ovf   = !is_zero && (exp_f >= fp_exp_ext_t'(EXP_MAX));
		flush = is_zero || (exp_f < fp_exp_ext_t'(1));          // Below min normal

		if (raw.special)
			word = raw.special_word;                             // NaN or inf wins
		else if (ovf)
			word = {raw.sign, FP_INF_MAG[FP_W-2:0]};
		else if (flush)
			word = {raw.sign, {(FP_W-1){1'b0}}};
		else
			word = {raw.sign, exp_f[EXP_W-1:0], mant_r[FRAC_W-1:0]};  // Carry leaves frac 0
	end

	//////////////////////////////////////////////////////////////////////
	// Output registers
	always_ff @(posedge fpu_if or negedge arst_n) begin
		if (!arst_n) begin
			result <= '0;
			flags  <= '0;
			fill   <= '0;
		end else begin
			result <= word;
			if (fill != 2'(FPU_LATENCY)) begin
				fill  <= fill + 1'b1;
				flags <= '0;                                // Stages still hold reset contents
			end else begin
				flags.zero     <= (word[FP_W-2:0] == '0);
				flags.inf      <= (word[FP_W-2:0] == FP_INF_MAG[FP_W-2:0]);
				flags.qnan     <= (&word[FP_W-2 -: EXP_W]) && (word[FRAC_W-1:0] != '0);
				flags.snan     <= raw.snan;                 // From classify
				flags.overflow <= ovf && !raw.special;      // inf operand is no overflow
			end
		end
	end

endmodule

// ==== design/fpu_pre_norm.sv ====
// Pre-normalize stage: add/sub alignment, product exponent and sign, special results
module fpu_pre_norm
	import fp_format_pkg::*, fpu_ctrl_pkg::*;
(
	input  logic     fpu_if,
	input  logic     arst_n,
	fpu_opnd_if.pre  opnd,
	fpu_align_if.src algn
);

	logic                        is_mul;
	logic                        sign_a, sign_b;      // sign_b flipped for subtract
	logic [FP_W-2:0]             mag_a, mag_b;        // Zero class forces magnitude 0
	logic                        swap, mag_eq, eff_sub;
	logic [FP_W-2:0]             mag_big, mag_small;
	fp_exp_t                     shift;
	logic [MANT_W-1:0]           mant_a, mant_b, mant_big, mant_small;
	logic [MANT_W+ALIGN_W-1:0]   shifted;
	logic [ALIGN_W-1:0]          aligned;             // Small operand, {mant, g, r, s}
	logic                        inf_a, inf_b, zero_a, zero_b;
	logic                        make_qnan, special;
	logic                        sign_res;
	fp_exp_ext_t                 exp_res;
	fp_wide_t                    frac_a_d, frac_b_d;

	always_comb begin
		is_mul = (opnd.op != OP_ADD) && (opnd.op != OP_SUB);
		zero_a = (opnd.cls_a == CLS_ZERO);
		zero_b = (opnd.cls_b == CLS_ZERO);
		inf_a  = (opnd.cls_a == CLS_INF);
		inf_b  = (opnd.cls_b == CLS_INF);
		sign_a = opnd.opa[FP_W-1];
		sign_b = opnd.opb[FP_W-1] ^ (opnd.op == OP_SUB);
		mag_a  = zero_a ? '0 : opnd.opa[FP_W-2:0];
		mag_b  = zero_b ? '0 : opnd.opb[FP_W-2:0];
		mant_a = {!zero_a, mag_a[FRAC_W-1:0]};           // Hidden bit back in
		mant_b = {!zero_b, mag_b[FRAC_W-1:0]};

		// Order by magnitude
		swap       = (mag_b > mag_a);
		mag_eq     = (mag_a == mag_b);
		eff_sub    = sign_a ^ sign_b;
		mag_big    = swap ? mag_b : mag_a;
		mag_small  = swap ? mag_a : mag_b;
		mant_big   = swap ? mant_b : mant_a;
		mant_small = swap ? mant_a : mant_b;
		shift      = mag_big[FP_W-2 -: EXP_W] - mag_small[FP_W-2 -: EXP_W];

		// Right shift with sticky collection
		shifted = {mant_small, {ALIGN_W{1'b0}}} >> shift;
		if (shift > fp_exp_t'(ALIGN_W - 1))
			aligned = {{(ALIGN_W-1){1'b0}}, |mant_small};  // All of it is sticky
		else
			aligned = {shifted[MANT_W+ALIGN_W-1 -: ALIGN_W-1], |shifted[MANT_W:0]};

		if (is_mul) begin
			sign_res = opnd.opa[FP_W-1] ^ opnd.opb[FP_W-1];
			exp_res  = fp_exp_ext_t'(mag_a[FP_W-2 -: EXP_W]) +
				fp_exp_ext_t'(mag_b[FP_W-2 -: EXP_W]) - fp_exp_ext_t'(EXP_BIAS);
			frac_a_d = {{(WIDE_W-MANT_W){1'b0}}, mant_a};
			frac_b_d = {{(WIDE_W-MANT_W){1'b0}}, mant_b};
		end else begin
			sign_res = (eff_sub && mag_eq) ? 1'b0 : (swap ? sign_b : sign_a); // x-x is +0
			exp_res  = fp_exp_ext_t'(mag_big[FP_W-2 -: EXP_W]);
			frac_a_d = {1'b0, mant_big, 3'b000, {PAD_W{1'b0}}};  // Hidden bit at WIDE_W-2
			frac_b_d = {1'b0, aligned, {PAD_W{1'b0}}};
		end

		// Special results decided here only
		make_qnan = (opnd.cls_a inside {CLS_QNAN, CLS_SNAN}) ||
			(opnd.cls_b inside {CLS_QNAN, CLS_SNAN}) ||
			(!is_mul && inf_a && inf_b && eff_sub) ||              // inf - inf
			(is_mul && ((inf_a && zero_b) || (zero_a && inf_b)));  // inf * 0
		special = make_qnan || inf_a || inf_b;
	end

	always_ff @(posedge fpu_if or negedge arst_n) begin
		if (!arst_n) begin
			algn.op           <= OP_ADD;
			algn.frac_a       <= '0;
			algn.frac_b       <= '0;
			algn.eff_sub      <= 1'b0;
			algn.sign         <= 1'b0;
			algn.exp          <= '0;
			algn.special      <= 1'b0;
			algn.special_word <= '0;
			algn.snan         <= 1'b0;
		end else begin
			algn.op           <= opnd.op;
			algn.frac_a       <= frac_a_d;
			algn.frac_b       <= frac_b_d;
			algn.eff_sub      <= !is_mul && eff_sub;
			algn.sign         <= sign_res;
			algn.exp          <= exp_res;
			algn.special      <= special;
			algn.special_word <= make_qnan ? FP_QNAN : {sign_res, FP_INF_MAG[FP_W-2:0]};
			algn.snan         <= opnd.snan;
		end
	end

endmodule

// ==== design/fpu_stage_ifs.sv ====
// Stage boundary interfaces: classified operands, aligned and raw datapath bundles
interface fpu_opnd_if
	import fp_format_pkg::*, fpu_ctrl_pkg::*;
();
	fp_word_t  opa;      // Captured operands
	fp_word_t  opb;
	fpu_op_e   op;
	fp_class_e cls_a;    // Per-operand class
	fp_class_e cls_b;
	logic      snan;     // Either operand signaling

	modport cls (output opa, opb, op, cls_a, cls_b, snan);
	modport pre (input opa, opb, op, cls_a, cls_b, snan);
endinterface

interface fpu_align_if
	import fp_format_pkg::*, fpu_ctrl_pkg::*;
();
	fpu_op_e     op;
	fp_wide_t    frac_a;        // Aligned fraction a, or raw sum/product
	fp_wide_t    frac_b;        // Aligned fraction b
	logic        eff_sub;       // Magnitudes subtract
	logic        sign;          // Result sign
	fp_exp_ext_t exp;           // Result exponent before normalization
	logic        special;       // Use special_word instead of datapath
	fp_word_t    special_word;
	logic        snan;

	modport src (output op, frac_a, frac_b, eff_sub, sign, exp, special, special_word, snan);
	modport dst (input op, frac_a, frac_b, eff_sub, sign, exp, special, special_word, snan);
endinterface

// ==== design/fpu_top.sv ====
// FPU top level: four-stage add/sub/mul pipeline with plain ports
module fpu_top
	import fp_format_pkg::*, fpu_ctrl_pkg::*;
(
	input  logic       fpu_if,     // Clock
	input  logic       arst_n,
	input  fp_word_t   opa,
	input  fp_word_t   opb,
	input  fpu_op_e    fpu_op,
	output fp_word_t   result,     // Three cycles after capture
	output fpu_flags_t flags
);

	fpu_opnd_if  opnd ();          // classify -> pre-norm
	fpu_align_if algn ();          // pre-norm -> arith
	fpu_align_if raw ();           // arith -> post-norm

	fp_classify u_classify (
		.fpu_if (fpu_if),
		.arst_n (arst_n),
		.opa    (opa),
		.opb    (opb),
		.fpu_op (fpu_op),
		.opnd   (opnd.cls)
	);

	fpu_pre_norm u_pre_norm (.fpu_if(fpu_if), .arst_n(arst_n), .opnd(opnd.pre), .algn(algn.src));

	fpu_arith u_arith (.fpu_if(fpu_if), .arst_n(arst_n), .algn(algn.dst), .raw(raw.src));

	fpu_post_norm u_post_norm (
		.fpu_if (fpu_if),
		.arst_n (arst_n),
		.raw    (raw.dst),
		.result (result),
		.flags  (flags)
	);

endmodule

// ==== project.f ====
design/fp_format_pkg.sv
design/fpu_ctrl_pkg.sv
design/fpu_stage_ifs.sv
design/fp_classify.sv
design/fpu_pre_norm.sv
design/fpu_arith.sv
design/fpu_post_norm.sv
design/fpu_top.sv
bench/fpu_assert.sv
bench/fpu_tb.sv
